// File: verilog/lsu_macros.svh
/*
 * load/store unit build constants
 * lane count, word width and buffer depths
 */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// lanes per warp instruction
`define LSU_NUM_LANES 4

// data and address width of one lane
`define LSU_XLEN 32

// outstanding loads in flight
`define LSU_PENDING_DEPTH 4

// entries per commit buffer
`define LSU_CBUF_DEPTH 2

`endif

// File: verilog/lsu_pkg.sv
/*
 * load/store unit types
 * lane vectors, formats and the packed channel payloads
 */
`include "lsu_macros.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]      word_t;
    typedef logic [`LSU_XLEN-3:0]      word_addr_t;
    typedef logic [`LSU_XLEN/8-1:0]    byteen_t;
    typedef logic [`LSU_NUM_LANES-1:0] lane_mask_t;
    typedef logic [1:0]                wid_t;
    typedef logic [4:0]                reg_idx_t;
    typedef logic [1:0]                align_t;

    // funct3 encoding
    typedef enum logic [2:0] {
        FMT_B  = 3'd0,
        FMT_H  = 3'd1,
        FMT_W  = 3'd2,
        FMT_BU = 3'd4,
        FMT_HU = 3'd5
    } lsu_fmt_e;

    typedef enum logic [1:0] {
        KIND_LOAD,
        KIND_STORE,
        KIND_FENCE
    } lsu_kind_e;

    typedef enum logic [0:0] {
        FENCE_IDLE,
        FENCE_WAIT
    } fence_state_e;

    typedef struct packed {
        wid_t                         wid;
        word_t                        pc;
        lane_mask_t                   tmask;
        reg_idx_t                     rd;
        lsu_kind_e                    kind;
        lsu_fmt_e                     fmt;
        word_t                        imm;
        word_t [`LSU_NUM_LANES-1:0]   rs1;
        word_t [`LSU_NUM_LANES-1:0]   rs2;
    } lsu_dispatch_t;

    typedef struct packed {
        logic                              rw;
        word_addr_t [`LSU_NUM_LANES-1:0]   word_addr;
        byteen_t [`LSU_NUM_LANES-1:0]      byteen;
        word_t [`LSU_NUM_LANES-1:0]        data;
    } mem_req_t;

    typedef struct packed {
        word_t [`LSU_NUM_LANES-1:0] data;
    } mem_rsp_t;

    // kept per load until its response returns
    typedef struct packed {
        wid_t                          wid;
        word_t                         pc;
        lane_mask_t                    tmask;
        reg_idx_t                      rd;
        lsu_fmt_e                      fmt;
        align_t [`LSU_NUM_LANES-1:0]   align;
    } load_meta_t;

    typedef struct packed {
        wid_t                         wid;
        word_t                        pc;
        lane_mask_t                   tmask;
        reg_idx_t                     rd;
        logic                         wb;
        word_t [`LSU_NUM_LANES-1:0]   data;
    } commit_t;

endpackage

// File: verilog/lsu_addr_gen.sv
/*
 * per-lane address generation
 * effective address, byte enables and store data alignment
 */
`timescale 1ns/10ps
`include "lsu_macros.svh"

module lsu_addr_gen (
    input  lsu_pkg::lsu_dispatch_t                 dispatch,
    output lsu_pkg::mem_req_t                      req,
    output lsu_pkg::align_t [`LSU_NUM_LANES-1:0]   align
);
    import lsu_pkg::*;

    localparam ASHIFT = $clog2(`LSU_XLEN / 8);

    always_comb begin
        word_t   full_addr;
        align_t  lane_align;
        byteen_t size_mask;

        req.rw = (dispatch.kind == KIND_STORE);
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            full_addr  = dispatch.rs1[i] + dispatch.imm;
            lane_align = full_addr[ASHIFT-1:0];

            // access size from the format, placed at the byte offset
            case (dispatch.fmt)
                FMT_B, FMT_BU: size_mask = byteen_t'(1) << lane_align;
                FMT_H, FMT_HU: size_mask = byteen_t'(3) << {lane_align[1], 1'b0};
                default:       size_mask = '1;
            endcase

            align[i]         = lane_align;
            req.word_addr[i] = full_addr[`LSU_XLEN-1:ASHIFT];
            // inactive lanes write nothing
            req.byteen[i]    = dispatch.tmask[i] ? size_mask : '0;
            req.data[i]      = dispatch.rs2[i] << {lane_align, 3'b000};
        end
    end

endmodule

// File: verilog/lsu_req_issue.sv
/*
 * request issue control
 * fence wait state and load/store/fence handshake steering
 */
`timescale 1ns/10ps

module lsu_req_issue (
    input  logic                clk,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  lsu_pkg::lsu_kind_e  kind,
    output logic                dispatch_ready,
    input  logic                mem_req_ready,
    output logic                mem_req_valid,
    input  logic                pending_empty,
    input  logic                pending_full,
    input  logic                mem_busy,
    input  logic                st_buf_ready,
    output logic                st_commit_push,
    output logic                load_push
);
    import lsu_pkg::*;

    fence_state_e fence_state;
    logic         is_load;
    logic         is_fence;
    logic         fence_clear;
    logic         issue_ok;
    logic         dispatch_fire;

    assign is_load     = (kind == KIND_LOAD);
    assign is_fence    = (kind == KIND_FENCE);
    assign fence_clear = pending_empty && !mem_busy;

    // loads need queue space, stores need a commit slot
    assign issue_ok = (fence_state == FENCE_IDLE) && (is_load ? !pending_full : st_buf_ready);

    assign mem_req_valid  = dispatch_valid && !is_fence && issue_ok;
    assign dispatch_ready = is_fence ? (fence_clear && st_buf_ready)
                                     : (mem_req_ready && issue_ok);
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    assign load_push      = dispatch_fire && is_load;
    // fences commit through the store path
    assign st_commit_push = dispatch_fire && !is_load;

    always_ff @(posedge clk) begin
        if (reset) begin
            fence_state <= FENCE_IDLE;
        end else begin
            case (fence_state)
                FENCE_IDLE: if (dispatch_valid && is_fence && !fence_clear) begin
                    fence_state <= FENCE_WAIT;
                end
                FENCE_WAIT: if (fence_clear) begin
                    fence_state <= FENCE_IDLE;
                end
                default: fence_state <= FENCE_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/lsu_pending_queue.sv
/*
 * pending load queue
 * in-order FIFO of load metadata awaiting memory responses
 */
`timescale 1ns/10ps
`include "lsu_macros.svh"

module lsu_pending_queue (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  lsu_pkg::load_meta_t meta_in,
    input  logic                pop,
    output lsu_pkg::load_meta_t meta_out,
    output logic                empty,
    output logic                full
);
    import lsu_pkg::*;

    localparam AW = $clog2(`LSU_PENDING_DEPTH);

    load_meta_t entries [`LSU_PENDING_DEPTH];

    // extra top bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr[AW-1:0]] <= meta_in;
        end
    end

    assign meta_out = entries[rd_ptr[AW-1:0]];
    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);

endmodule

// File: verilog/lsu_load_format.sv
/*
 * load response formatting
 * byte/half selection and sign or zero extension per lane
 */
`timescale 1ns/10ps
`include "lsu_macros.svh"

module lsu_load_format (
    input  lsu_pkg::mem_rsp_t   rsp,
    input  lsu_pkg::load_meta_t meta,
    output lsu_pkg::commit_t    result
);
    import lsu_pkg::*;

    always_comb begin
        logic [15:0] data16;
        logic [7:0]  data8;

        result.wid   = meta.wid;
        result.pc    = meta.pc;
        result.tmask = meta.tmask;
        result.rd    = meta.rd;
        result.wb    = 1'b1;

        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            // half by align bit 1, then byte by align bit 0
            data16 = meta.align[i][1] ? rsp.data[i][31:16] : rsp.data[i][15:0];
            data8  = meta.align[i][0] ? data16[15:8] : data16[7:0];

            case (meta.fmt)
                FMT_B:   result.data[i] = word_t'(signed'(data8));
                FMT_H:   result.data[i] = word_t'(signed'(data16));
                FMT_BU:  result.data[i] = word_t'(data8);
                FMT_HU:  result.data[i] = word_t'(data16);
                default: result.data[i] = rsp.data[i];
            endcase
        end
    end

endmodule

// File: verilog/lsu_commit_arb.sv
/*
 * commit arbiter
 * store and load commit buffers, round-robin onto one commit port
 */
`timescale 1ns/10ps
`include "lsu_macros.svh"

module lsu_commit_arb (
    input  logic             clk,
    input  logic             reset,
    input  logic             st_valid,
    input  lsu_pkg::commit_t st_commit,
    output logic             st_ready,
    input  logic             ld_valid,
    input  lsu_pkg::commit_t ld_commit,
    output logic             ld_ready,
    output logic             commit_valid,
    output lsu_pkg::commit_t commit,
    input  logic             commit_ready
);
    import lsu_pkg::*;

    localparam AW = $clog2(`LSU_CBUF_DEPTH);

    // source 0 is the store path, source 1 the load path
    logic [1:0]          src_valid;
    commit_t [1:0]       src_commit;
    wire [1:0]           src_ready;
    wire [1:0]           buf_nonempty;
    wire commit_t [1:0]  buf_head;
    logic [1:0]          buf_pop;
    logic                last_grant;
    logic                sel;
    logic                commit_fire;

    assign src_valid  = {ld_valid, st_valid};
    assign src_commit = {ld_commit, st_commit};
    assign st_ready   = src_ready[0];
    assign ld_ready   = src_ready[1];

    for (genvar s = 0; s < 2; s++) begin : g_buf
        commit_t     entries [`LSU_CBUF_DEPTH];
        logic [AW-1:0] wr_ptr;
        logic [AW-1:0] rd_ptr;
        logic [AW:0]   count;
        logic          push;

        assign push            = src_valid[s] && src_ready[s];
        assign src_ready[s]    = (count < (AW+1)'(`LSU_CBUF_DEPTH));
        assign buf_nonempty[s] = (count != '0);
        assign buf_head[s]     = entries[rd_ptr];

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == AW'(`LSU_CBUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (buf_pop[s]) begin
                    rd_ptr <= (rd_ptr == AW'(`LSU_CBUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
                case ({push, buf_pop[s]})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                entries[wr_ptr] <= src_commit[s];
            end
        end
    end

    // alternate when both wait
    assign sel          = (buf_nonempty == 2'b11) ? ~last_grant : buf_nonempty[1];
    assign commit_valid = |buf_nonempty;
    assign commit       = buf_head[sel];
    assign commit_fire  = commit_valid && commit_ready;
    assign buf_pop      = {commit_fire && sel, commit_fire && !sel};

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= 1'b0;
        end else if (commit_fire) begin
            last_grant <= sel;
        end
    end

endmodule

// File: verilog/lsu_unit.sv
/*
 * SIMD load/store unit top
 * dispatch to memory request, in-order load return, shared commit port
 */
`timescale 1ns/10ps
`include "lsu_macros.svh"

module lsu_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dispatch_valid,
    input  lsu_pkg::lsu_dispatch_t dispatch,
    output logic                   dispatch_ready,
    output logic                   mem_req_valid,
    output lsu_pkg::mem_req_t      mem_req,
    input  logic                   mem_req_ready,
    input  logic                   mem_rsp_valid,
    input  lsu_pkg::mem_rsp_t      mem_rsp,
    output logic                   mem_rsp_ready,
    input  logic                   mem_busy,
    output logic                   commit_valid,
    output lsu_pkg::commit_t       commit,
    input  logic                   commit_ready
);
    import lsu_pkg::*;

    align_t [`LSU_NUM_LANES-1:0] req_align;
    load_meta_t                  meta_in;
    load_meta_t                  meta_out;
    commit_t                     st_commit;
    commit_t                     ld_commit;
    logic                        pending_empty;
    logic                        pending_full;
    logic                        st_buf_ready;
    logic                        st_commit_push;
    logic                        load_push;
    logic                        mem_rsp_fire;

    lsu_addr_gen i_addr_gen (
        .dispatch (dispatch),
        .req      (mem_req),
        .align    (req_align)
    );

    lsu_req_issue i_req_issue (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .kind           (dispatch.kind),
        .dispatch_ready (dispatch_ready),
        .mem_req_ready  (mem_req_ready),
        .mem_req_valid  (mem_req_valid),
        .pending_empty  (pending_empty),
        .pending_full   (pending_full),
        .mem_busy       (mem_busy),
        .st_buf_ready   (st_buf_ready),
        .st_commit_push (st_commit_push),
        .load_push      (load_push)
    );

    always_comb begin
        meta_in.wid   = dispatch.wid;
        meta_in.pc    = dispatch.pc;
        meta_in.tmask = dispatch.tmask;
        meta_in.rd    = dispatch.rd;
        meta_in.fmt   = dispatch.fmt;
        meta_in.align = req_align;
    end

    assign mem_rsp_fire = mem_rsp_valid && mem_rsp_ready;

    lsu_pending_queue i_pending_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (load_push),
        .meta_in  (meta_in),
        .pop      (mem_rsp_fire),
        .meta_out (meta_out),
        .empty    (pending_empty),
        .full     (pending_full)
    );

    lsu_load_format i_load_format (
        .rsp    (mem_rsp),
        .meta   (meta_out),
        .result (ld_commit)
    );

    // stores and fences commit with no write-back
    always_comb begin
        st_commit.wid   = dispatch.wid;
        st_commit.pc    = dispatch.pc;
        st_commit.tmask = dispatch.tmask;
        st_commit.rd    = dispatch.rd;
        st_commit.wb    = 1'b0;
        st_commit.data  = '0;
    end

    lsu_commit_arb i_commit_arb (
        .clk          (clk),
        .reset        (reset),
        .st_valid     (st_commit_push),
        .st_commit    (st_commit),
        .st_ready     (st_buf_ready),
        .ld_valid     (mem_rsp_valid),
        .ld_commit    (ld_commit),
        .ld_ready     (mem_rsp_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

// File: test/lsu_tb.sv
/*
 * load/store unit testbench
 * random memory model, reference load values and commit order checks
 */
`timescale 1ns/10ps
`include "lsu_macros.svh"

module lsu_tb;
    import lsu_pkg::*;

    logic          clk;
    logic          reset;
    logic          dispatch_valid;
    lsu_dispatch_t dispatch;
    logic          dispatch_ready;
    logic          mem_req_valid;
    mem_req_t      mem_req;
    logic          mem_req_ready;
    logic          mem_rsp_valid;
    mem_rsp_t      mem_rsp;
    logic          mem_rsp_ready;
    logic          mem_busy;
    logic          commit_valid;
    commit_t       commit;
    logic          commit_ready;

    logic [31:0] lfsr;
    word_t       mem_model [256];
    mem_rsp_t    rsp_q [$];
    commit_t     st_exp_q [$];
    commit_t     ld_exp_q [$];
    int          fence_q [$];
    int          rsp_delay;
    int          ld_issued;
    int          ld_done;
    int          mismatches;
    int          other_errors;
    logic        req_rand;
    logic        busy_force;
    logic        cr_rand;
    logic        rsp_taken;

    lsu_unit i_lsu_unit (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int access_size(input lsu_fmt_e fmt);
        if (fmt == FMT_B || fmt == FMT_BU) return 1;
        if (fmt == FMT_H || fmt == FMT_HU) return 2;
        return 4;
    endfunction

    function automatic mem_req_t expect_req(input lsu_dispatch_t d);
        mem_req_t r;
        word_t    addr;
        int       off;
        r.rw = (d.kind == KIND_STORE);
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            addr = d.rs1[i] + d.imm;
            off  = addr[1:0];
            r.word_addr[i] = addr[31:2];
            for (int b = 0; b < 4; b++) begin
                r.byteen[i][b] = d.tmask[i] && (b >= off) && (b < off + access_size(d.fmt));
            end
            r.data[i] = d.rs2[i] << (8 * off);
        end
        return r;
    endfunction

    // expected load commit from the model memory
    function automatic commit_t ref_load(input lsu_dispatch_t d);
        commit_t c;
        word_t   addr;
        word_t   w;
        c.wid   = d.wid;
        c.pc    = d.pc;
        c.tmask = d.tmask;
        c.rd    = d.rd;
        c.wb    = 1'b1;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            addr = d.rs1[i] + d.imm;
            w    = mem_model[addr[9:2]] >> (8 * addr[1:0]);
            case (d.fmt)
                FMT_B:   c.data[i] = {{24{w[7]}}, w[7:0]};
                FMT_BU:  c.data[i] = {24'h0, w[7:0]};
                FMT_H:   c.data[i] = {{16{w[15]}}, w[15:0]};
                FMT_HU:  c.data[i] = {16'h0, w[15:0]};
                default: c.data[i] = w;
            endcase
        end
        return c;
    endfunction

    function automatic commit_t store_commit(input lsu_dispatch_t d);
        commit_t c;
        c.wid   = d.wid;
        c.pc    = d.pc;
        c.tmask = d.tmask;
        c.rd    = d.rd;
        c.wb    = 1'b0;
        c.data  = '0;
        return c;
    endfunction

    function automatic lsu_dispatch_t make_op(input lsu_kind_e kind, input lsu_fmt_e fmt,
                                              input int off, input lane_mask_t mask,
                                              input int base, input int imm);
        lsu_dispatch_t d;
        d.wid   = wid_t'(rand_bits(2));
        d.pc    = rand_bits(30) << 2;
        d.tmask = mask;
        d.rd    = reg_idx_t'(rand_bits(5));
        d.kind  = kind;
        d.fmt   = fmt;
        d.imm   = word_t'(imm);
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            d.rs1[i] = word_t'(((base + 3 * i) % 200) * 4 + off);
            d.rs2[i] = rand_bits(32);
        end
        return d;
    endfunction

    task automatic check_req(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: mem_req got %h expected %h", $time, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_store_commit(input commit_t got, input commit_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: store commit got %h expected %h", $time, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_load_commit(input commit_t got, input commit_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: load commit got %h expected %h", $time, got, exp);
            mismatches++;
        end
    endtask

    task automatic send(input lsu_dispatch_t d);
        int n;
        n = 0;
        dispatch_valid = 1'b1;
        dispatch       = d;
        do begin
            @(posedge clk);
            n++;
        end while (!dispatch_ready && n < 500);
        if (!dispatch_ready) begin
            $display("timeout: dispatch was never accepted at %0t", $time);
            other_errors++;
        end
        #1;
        dispatch_valid = 1'b0;
    endtask

    // memory model, expectation bookkeeping and commit compare
    always @(posedge clk) begin
        rsp_taken = 1'b0;
        if (!reset) begin
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_q.pop_front());
                rsp_taken = 1'b1;
                rsp_delay = rand_bits(2);
            end
            if (dispatch_valid && dispatch_ready) begin
                if (dispatch.kind == KIND_LOAD) begin
                    ld_exp_q.push_back(ref_load(dispatch));
                    ld_issued++;
                end else begin
                    st_exp_q.push_back(store_commit(dispatch));
                    fence_q.push_back(dispatch.kind == KIND_FENCE ? ld_issued : -1);
                end
                if (dispatch.kind == KIND_FENCE) begin
                    if (mem_busy || mem_rsp_valid || rsp_q.size() != 0) begin
                        $display("fence accepted with loads outstanding or memory busy at %0t",
                                 $time);
                        other_errors++;
                    end
                end else if (!(mem_req_valid && mem_req_ready)) begin
                    $display("dispatch accepted without a memory request at %0t", $time);
                    other_errors++;
                end
            end
            if (mem_req_valid && dispatch.kind == KIND_FENCE) begin
                $display("memory request raised for a fence at %0t", $time);
                other_errors++;
            end
            if (mem_req_valid && mem_req_ready) begin
                check_req(mem_req, expect_req(dispatch));
                if (mem_req.rw) begin
                    for (int i = 0; i < `LSU_NUM_LANES; i++) begin
                        for (int b = 0; b < 4; b++) begin
                            if (mem_req.byteen[i][b]) begin
                                mem_model[mem_req.word_addr[i][7:0]][8*b +: 8] =
                                    mem_req.data[i][8*b +: 8];
                            end
                        end
                    end
                end else begin
                    mem_rsp_t r;
                    for (int i = 0; i < `LSU_NUM_LANES; i++) begin
                        r.data[i] = mem_model[mem_req.word_addr[i][7:0]];
                    end
                    rsp_q.push_back(r);
                end
            end
            if (commit_valid && commit_ready) begin
                if (commit.wb) begin
                    if (ld_exp_q.size() == 0) begin
                        $display("unexpected load commit at %0t", $time);
                        other_errors++;
                    end else begin
                        check_load_commit(commit, ld_exp_q.pop_front());
                        ld_done++;
                    end
                end else if (st_exp_q.size() == 0) begin
                    $display("unexpected store commit at %0t", $time);
                    other_errors++;
                end else begin
                    check_store_commit(commit, st_exp_q.pop_front());
                    if (fence_q.pop_front() > ld_done) begin
                        $display("fence committed before earlier loads at %0t", $time);
                        other_errors++;
                    end
                end
            end
        end
        #1;
        if (rsp_taken) begin
            mem_rsp_valid = 1'b0;
        end
        mem_req_ready = req_rand ? (rand_bits(2) != 0) : 1'b1;
        mem_busy      = busy_force || (rand_bits(3) == 0);
        commit_ready  = cr_rand ? (rand_bits(1) != 0) : 1'b1;
        if (!mem_rsp_valid && rsp_q.size() > 0) begin
            if (rsp_delay == 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp       = rsp_q[0];
            end else begin
                rsp_delay--;
            end
        end
    end

    initial begin
        lsu_fmt_e fmts [5];
        lsu_fmt_e f;
        int       n;
        fmts = '{FMT_B, FMT_H, FMT_W, FMT_BU, FMT_HU};
        clk = 0;
        reset = 1;
        dispatch_valid = 0;
        dispatch = '0;
        mem_req_ready = 0;
        mem_rsp_valid = 0;
        mem_rsp = '0;
        mem_busy = 0;
        commit_ready = 0;
        lfsr = 32'hedfb;
        rsp_delay = 0;
        ld_issued = 0;
        ld_done = 0;
        mismatches = 0;
        other_errors = 0;
        req_rand = 1;
        busy_force = 0;
        cr_rand = 0;
        for (int a = 0; a < 256; a++) begin
            mem_model[a] = (a * 32'h9e37_79b1) ^ 32'h8c35_f00d;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 0;

        // store sizes at every aligned offset
        for (int k = 0; k < 3; k++) begin
            for (int off = 0; off < 4; off += access_size(fmts[k])) begin
                send(make_op(KIND_STORE, fmts[k], off, 4'hf, 10 + off, 4 * off));
            end
        end
        // all load formats, random masks
        for (int k = 0; k < 5; k++) begin
            for (int off = 0; off < 4; off += access_size(fmts[k])) begin
                send(make_op(KIND_LOAD, fmts[k], off, lane_mask_t'(rand_bits(4) | 4'h1),
                             10 + off, 4 * off));
            end
        end
        // partial mask store, then read back the whole words
        send(make_op(KIND_STORE, FMT_W, 0, 4'b0101, 60, 8));
        send(make_op(KIND_STORE, FMT_B, 3, 4'b1000, 61, 8));
        send(make_op(KIND_LOAD, FMT_W, 0, 4'hf, 60, 8));
        send(make_op(KIND_LOAD, FMT_W, 0, 4'hf, 61, 8));

        // fence behind outstanding loads with memory busy
        busy_force = 1;
        req_rand = 0;
        for (int k = 0; k < 3; k++) begin
            send(make_op(KIND_LOAD, FMT_W, 0, 4'hf, 20 + k, 0));
        end
        fork
            send(make_op(KIND_FENCE, FMT_W, 0, 4'hf, 0, 0));
            begin
                repeat (12) @(posedge clk);
                busy_force = 0;
            end
        join
        // fence right behind loads, memory mostly idle
        for (int k = 0; k < 3; k++) begin
            send(make_op(KIND_LOAD, FMT_W, 0, 4'hf, 30 + k, 0));
        end
        send(make_op(KIND_FENCE, FMT_W, 0, 4'hf, 0, 0));
        req_rand = 1;

        // random mix under commit back-pressure
        cr_rand = 1;
        for (int k = 0; k < 60; k++) begin
            f = fmts[rand_bits(3) % 5];
            n = (access_size(f) == 1) ? rand_bits(2)
              : (access_size(f) == 2) ? 2 * rand_bits(1) : 0;
            send(make_op(rand_bits(1) ? KIND_STORE : KIND_LOAD, f, n,
                         lane_mask_t'(rand_bits(4)), rand_bits(7), 4 * rand_bits(3)));
        end

        n = 0;
        while ((st_exp_q.size() > 0 || ld_exp_q.size() > 0) && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (st_exp_q.size() > 0 || ld_exp_q.size() > 0) begin
            $display("timeout: %0d stores and %0d loads never committed",
                     st_exp_q.size(), ld_exp_q.size());
            other_errors++;
        end

        $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_addr_gen.sv
verilog/lsu_req_issue.sv
verilog/lsu_pending_queue.sv
verilog/lsu_load_format.sv
verilog/lsu_commit_arb.sv
verilog/lsu_unit.sv
test/lsu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module lsu_tb \
    -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0
